// File: build.f
mem_island_pkg.sv
narrow_router.sv
wide_splitter.sv
mem_bank.sv
rsp_router.sv
mem_island_top.sv
tb_mem_island.sv

// File: mem_bank.sv
/*
  One SRAM bank with narrow-over-wide priority at its input.
  Byte-enabled writes, registered read port.
*/
`timescale 1ns/1ps

module mem_bank
  import mem_island_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       narrow_valid_i,
  input  bank_req_t                  narrow_req_i,
  input  logic                       wide_valid_i,
  input  bank_req_t                  wide_req_i,
  output logic                       wide_accept_o,
  output logic [NarrowDataWidth-1:0] rdata_o
);

  logic [NarrowDataWidth-1:0] mem_q [WordsPerBank];
  logic [NarrowDataWidth-1:0] rdata_q;
  bank_req_t                  sel_req;
  logic                       sel_valid;

  // Narrow always wins the bank
  assign wide_accept_o = ~narrow_valid_i;
  assign sel_valid     = narrow_valid_i | wide_valid_i;
  assign sel_req       = narrow_valid_i ? narrow_req_i : wide_req_i;

  always_ff @(posedge clk_i) begin
    if (sel_valid && sel_req.we) begin
      for (int i = 0; i < NarrowStrbWidth; i++) begin
        if (sel_req.strb[i]) begin
          mem_q[sel_req.addr][i*8 +: 8] <= sel_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Read returns contents from before this edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel_valid && !sel_req.we) begin
      rdata_q <= mem_q[sel_req.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: mem_island_pkg.sv
/*
  Shared widths, bank counts and address field positions of the memory island.
  Request structs for the narrow ports, the wide port and a single bank.
*/
package mem_island_pkg;

  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 64;
  localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
  localparam int unsigned WideStrbWidth   = WideDataWidth / 8;

  localparam int unsigned NumWideBanks  = 2;
  localparam int unsigned NumSubBanks   = WideDataWidth / NarrowDataWidth;
  localparam int unsigned NumBanks      = NumWideBanks * NumSubBanks;
  localparam int unsigned BankAddrWidth = 8;
  localparam int unsigned WordsPerBank  = 1 << BankAddrWidth;
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);

  // Address fields from the top are word in bank, wide bank, sub-bank and byte
  localparam int unsigned ByteOffWidth = $clog2(NarrowStrbWidth);
  localparam int unsigned BankAddrLsb  = ByteOffWidth + BankSelWidth;

  typedef struct packed {
    logic [AddrWidth-1:0]       addr;
    logic                       we;
    logic [NarrowDataWidth-1:0] wdata;
    logic [NarrowStrbWidth-1:0] strb;
  } narrow_req_t;

  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic                     we;
    logic [WideDataWidth-1:0] wdata;
    logic [WideStrbWidth-1:0] strb;
  } wide_req_t;

  typedef struct packed {
    logic [BankAddrWidth-1:0]   addr;
    logic                       we;
    logic [NarrowDataWidth-1:0] wdata;
    logic [NarrowStrbWidth-1:0] strb;
  } bank_req_t;

endpackage

// File: mem_island_top.sv
/*
  Memory island top with the narrow ports, one wide port and four interleaved banks.
*/
`timescale 1ns/1ps

module mem_island_top
  import mem_island_pkg::*;
#(
  parameter int unsigned NumNarrow = 2
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic        [NumNarrow-1:0]               narrow_req_i,
  input  narrow_req_t [NumNarrow-1:0]               narrow_data_i,
  output logic        [NumNarrow-1:0]               narrow_gnt_o,
  output logic        [NumNarrow-1:0]               narrow_rvalid_o,
  output logic        [NumNarrow-1:0][NarrowDataWidth-1:0] narrow_rdata_o,
  input  logic                                      wide_req_i,
  input  wide_req_t                                 wide_data_i,
  output logic                                      wide_gnt_o,
  output logic                                      wide_rvalid_o,
  output logic        [WideDataWidth-1:0]           wide_rdata_o
);

  localparam int unsigned PortIdxWidth = (NumNarrow > 1) ? $clog2(NumNarrow) : 1;

  logic      [NumBanks-1:0]                    nb_valid;
  bank_req_t [NumBanks-1:0]                    nb_req;
  logic      [NumBanks-1:0][PortIdxWidth-1:0]  nb_winner;
  logic      [NumBanks-1:0]                    wb_valid;
  bank_req_t [NumBanks-1:0]                    wb_req;
  logic      [NumBanks-1:0]                    wb_accept;
  logic      [NumBanks-1:0][NarrowDataWidth-1:0] bank_rdata;

  narrow_router #(
    .NumNarrow    (NumNarrow),
    .PortIdxWidth (PortIdxWidth)
  ) i_narrow_router (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (narrow_req_i),
    .data_i        (narrow_data_i),
    .gnt_o         (narrow_gnt_o),
    .bank_valid_o  (nb_valid),
    .bank_req_o    (nb_req),
    .bank_winner_o (nb_winner)
  );

  wide_splitter i_wide_splitter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (wide_req_i),
    .data_i        (wide_data_i),
    .bank_valid_o  (wb_valid),
    .bank_req_o    (wb_req),
    .bank_accept_i (wb_accept),
    .gnt_o         (wide_gnt_o),
    .rdata_i       (bank_rdata),
    .rvalid_o      (wide_rvalid_o),
    .rdata_o       (wide_rdata_o)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    mem_bank i_mem_bank (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .narrow_valid_i (nb_valid[b]),
      .narrow_req_i   (nb_req[b]),
      .wide_valid_i   (wb_valid[b]),
      .wide_req_i     (wb_req[b]),
      .wide_accept_o  (wb_accept[b]),
      .rdata_o        (bank_rdata[b])
    );
  end

  rsp_router #(
    .NumNarrow    (NumNarrow),
    .PortIdxWidth (PortIdxWidth)
  ) i_rsp_router (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bank_valid_i  (nb_valid),
    .bank_winner_i (nb_winner),
    .bank_rdata_i  (bank_rdata),
    .rvalid_o      (narrow_rvalid_o),
    .rdata_o       (narrow_rdata_o)
  );

endmodule

// File: narrow_router.sv
/*
  Narrow request router with one round-robin arbiter per bank.
  Grants are combinational; only the arbiter pointers are stored.
*/
`timescale 1ns/1ps

module narrow_router
  import mem_island_pkg::*;
#(
  parameter int unsigned NumNarrow    = 2,
  parameter int unsigned PortIdxWidth = (NumNarrow > 1) ? $clog2(NumNarrow) : 1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic        [NumNarrow-1:0]             req_i,
  input  narrow_req_t [NumNarrow-1:0]             data_i,
  output logic        [NumNarrow-1:0]             gnt_o,
  output logic        [NumBanks-1:0]              bank_valid_o,
  output bank_req_t   [NumBanks-1:0]              bank_req_o,
  output logic        [NumBanks-1:0][PortIdxWidth-1:0] bank_winner_o
);

  logic [NumBanks-1:0][PortIdxWidth-1:0] rr_q;

  // Search each bank from its pointer and let the first hit win
  always_comb begin
    int idx;
    gnt_o         = '0;
    bank_valid_o  = '0;
    bank_req_o    = '0;
    bank_winner_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int k = 0; k < NumNarrow; k++) begin
        idx = int'(rr_q[b]) + k;
        if (idx >= NumNarrow) begin
          idx = idx - NumNarrow;
        end
        if (!bank_valid_o[b] && req_i[idx] &&
            data_i[idx].addr[ByteOffWidth +: BankSelWidth] == BankSelWidth'(b)) begin
          bank_valid_o[b]     = 1'b1;
          bank_winner_o[b]    = PortIdxWidth'(idx);
          gnt_o[idx]          = 1'b1;
          bank_req_o[b].addr  = data_i[idx].addr[BankAddrLsb +: BankAddrWidth];
          bank_req_o[b].we    = data_i[idx].we;
          bank_req_o[b].wdata = data_i[idx].wdata;
          bank_req_o[b].strb  = data_i[idx].strb;
        end
      end
    end
  end

  // Pointer moves one past the port that was just served
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_valid_o[b]) begin
          if (bank_winner_o[b] == PortIdxWidth'(NumNarrow - 1)) begin
            rr_q[b] <= '0;
          end else begin
            rr_q[b] <= bank_winner_o[b] + 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: rsp_router.sv
/*
  Narrow response path that remembers the granted port per bank
  and returns rvalid and read data one cycle later.
*/
`timescale 1ns/1ps

module rsp_router
  import mem_island_pkg::*;
#(
  parameter int unsigned NumNarrow    = 2,
  parameter int unsigned PortIdxWidth = (NumNarrow > 1) ? $clog2(NumNarrow) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [NumBanks-1:0]                       bank_valid_i,
  input  logic [NumBanks-1:0][PortIdxWidth-1:0]     bank_winner_i,
  input  logic [NumBanks-1:0][NarrowDataWidth-1:0]  bank_rdata_i,
  output logic [NumNarrow-1:0]                      rvalid_o,
  output logic [NumNarrow-1:0][NarrowDataWidth-1:0] rdata_o
);

  logic [NumBanks-1:0]                   valid_q;
  logic [NumBanks-1:0][PortIdxWidth-1:0] winner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      winner_q <= '0;
    end else begin
      valid_q  <= bank_valid_i;
      winner_q <= bank_winner_i;
    end
  end

  // A port wins at most one bank per cycle
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (valid_q[b]) begin
        rvalid_o[winner_q[b]] = 1'b1;
        rdata_o[winner_q[b]]  = bank_rdata_i[b];
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the memory island testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_mem_island -o sim_tb > compile.log 2>&1
if [ $? -ne 0 ]; then
  echo "Compilation failed, see compile.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// File: tb_mem_island.sv
/*
  Memory island testbench with clock, reset, LCG stimulus and a reference memory.
  Concurrent assertions on timing, priority and arbitration, and the closing report.
*/
`timescale 1ns/1ps

module tb_mem_island
  import mem_island_pkg::*;
();

  localparam int unsigned NumNarrow     = 2;
  localparam int          MaxWaitCycles = 20;

  logic                                      clk_i;
  logic                                      rst_ni;
  logic        [NumNarrow-1:0]               narrow_req;
  narrow_req_t [NumNarrow-1:0]               narrow_data;
  logic        [NumNarrow-1:0]               narrow_gnt_o;
  logic        [NumNarrow-1:0]               narrow_rvalid_o;
  logic        [NumNarrow-1:0][NarrowDataWidth-1:0] narrow_rdata_o;
  logic                                      wide_req;
  wide_req_t                                 wide_data;
  logic                                      wide_gnt_o;
  logic                                      wide_rvalid_o;
  logic        [WideDataWidth-1:0]           wide_rdata_o;

  int          errors;
  int          checks;
  string       test_name;
  logic [31:0] lcg_state;
  logic        same_bank;
  logic        narrow_hits_wide;
  // Word index is address bits 11:2 with the bank in the low two bits
  logic [31:0] model [1024];

  mem_island_top #(
    .NumNarrow (NumNarrow)
  ) uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .narrow_req_i    (narrow_req),
    .narrow_data_i   (narrow_data),
    .narrow_gnt_o    (narrow_gnt_o),
    .narrow_rvalid_o (narrow_rvalid_o),
    .narrow_rdata_o  (narrow_rdata_o),
    .wide_req_i      (wide_req),
    .wide_data_i     (wide_data),
    .wide_gnt_o      (wide_gnt_o),
    .wide_rvalid_o   (wide_rvalid_o),
    .wide_rdata_o    (wide_rdata_o)
  );

  always #2 clk_i = ~clk_i;

  assign same_bank = narrow_data[0].addr[3:2] == narrow_data[1].addr[3:2];

  always_comb begin
    narrow_hits_wide = 1'b0;
    for (int n = 0; n < NumNarrow; n++) begin
      if (narrow_req[n] && narrow_data[n].addr[3] == wide_data.addr[3]) begin
        narrow_hits_wide = 1'b1;
      end
    end
  end

  for (genvar n = 0; n < NumNarrow; n++) begin : gen_rvalid_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      narrow_rvalid_o[n] == $past(narrow_req[n] & narrow_gnt_o[n]))
    else begin
      errors++;
      $display("Narrow port %0d rvalid is not exactly one cycle after its grant", n);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_rvalid_o == $past(wide_req & wide_gnt_o))
  else begin
    errors++;
    $display("Wide rvalid is not exactly one cycle after its grant");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(narrow_hits_wide && wide_gnt_o))
  else begin
    errors++;
    $display("Wide port granted while a narrow request targets its wide bank");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(same_bank && (&narrow_gnt_o)))
  else begin
    errors++;
    $display("Two narrow ports granted together on the same bank");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((&narrow_req) && !same_bank) |-> (&narrow_gnt_o))
  else begin
    errors++;
    $display("Narrow ports on different banks were not granted together");
  end

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function void model_write(input logic [9:0] idx, input logic [31:0] wdata,
                            input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        model[idx][i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
  endfunction

  task check_value(input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  task narrow_access(input int p, input logic [31:0] req_addr, input logic req_we,
                     input logic [31:0] req_wdata, input logic [3:0] req_strb);
    int          cnt;
    logic [31:0] exp;
    @(posedge clk_i);
    narrow_req[p]  <= 1'b1;
    narrow_data[p] <= '{addr: req_addr, we: req_we, wdata: req_wdata, strb: req_strb};
    cnt = 0;
    @(negedge clk_i);
    while (!narrow_gnt_o[p] && cnt < MaxWaitCycles) begin
      @(negedge clk_i);
      cnt++;
    end
    @(posedge clk_i);
    narrow_req[p] <= 1'b0;
    if (cnt >= MaxWaitCycles) begin
      errors++;
      $display("Timeout: narrow port %0d was never granted", p);
      return;
    end
    exp = model[req_addr[11:2]];
    if (req_we) begin
      model_write(req_addr[11:2], req_wdata, req_strb);
    end
    cnt = 0;
    @(negedge clk_i);
    while (!narrow_rvalid_o[p] && cnt < MaxWaitCycles) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!narrow_rvalid_o[p]) begin
      errors++;
      $display("Timeout: no response on narrow port %0d", p);
    end else if (!req_we) begin
      check_value(64'(exp), 64'(narrow_rdata_o[p]));
    end
  endtask

  task wide_access(input logic [31:0] req_addr, input logic req_we,
                   input logic [63:0] req_wdata, input logic [7:0] req_strb);
    int          cnt;
    logic [63:0] exp;
    logic [9:0]  lo;
    lo = {req_addr[11:3], 1'b0};
    @(posedge clk_i);
    wide_req  <= 1'b1;
    wide_data <= '{addr: req_addr, we: req_we, wdata: req_wdata, strb: req_strb};
    cnt = 0;
    @(negedge clk_i);
    while (!wide_gnt_o && cnt < MaxWaitCycles) begin
      @(negedge clk_i);
      cnt++;
    end
    @(posedge clk_i);
    wide_req <= 1'b0;
    if (cnt >= MaxWaitCycles) begin
      errors++;
      $display("Timeout: wide port was never granted");
      return;
    end
    // Low half lives at bit 2 clear and high half at bit 2 set
    exp = {model[lo | 10'd1], model[lo]};
    if (req_we) begin
      model_write(lo, req_wdata[31:0], req_strb[3:0]);
      model_write(lo | 10'd1, req_wdata[63:32], req_strb[7:4]);
    end
    cnt = 0;
    @(negedge clk_i);
    while (!wide_rvalid_o && cnt < MaxWaitCycles) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!wide_rvalid_o) begin
      errors++;
      $display("Timeout: no response on the wide port");
    end else if (!req_we) begin
      check_value(exp, wide_rdata_o);
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [63:0] wdata64;
    logic [1:0]  prev_gnt;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    narrow_req  = '0;
    narrow_data = '0;
    wide_req    = 1'b0;
    wide_data   = '0;
    errors      = 0;
    checks      = 0;
    lcg_state   = 32'd85;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "reset_rvalid";
    @(negedge clk_i);
    check_value(64'd0, 64'({wide_rvalid_o, narrow_rvalid_o}));

    test_name = "narrow_write_read";
    for (int i = 0; i < 16; i++) begin
      addr = next_random();
      narrow_access(i % 2, addr, 1'b1, next_random(), 4'hF);
      narrow_access((i + 1) % 2, addr, 1'b0, '0, '0);
    end
    narrow_access(0, addr, 1'b1, next_random(), 4'b0110);
    narrow_access(1, addr, 1'b0, '0, '0);

    test_name = "wide_narrow_coherence";
    addr = next_random();
    wide_access(addr, 1'b1, {next_random(), next_random()}, 8'hFF);
    narrow_access(0, {addr[31:3], 3'b000}, 1'b0, '0, '0);
    narrow_access(1, {addr[31:3], 3'b100}, 1'b0, '0, '0);
    addr = next_random();
    narrow_access(1, {addr[31:3], 3'b000}, 1'b1, next_random(), 4'hF);
    narrow_access(0, {addr[31:3], 3'b100}, 1'b1, next_random(), 4'hF);
    wide_access(addr, 1'b0, '0, '0);
    wide_access(addr, 1'b1, {next_random(), next_random()}, 8'hA5);
    wide_access(addr, 1'b0, '0, '0);

    test_name = "narrow_priority";
    addr    = next_random();
    wdata64 = {next_random(), next_random()};
    fork
      begin
        @(posedge clk_i);
        narrow_req[0]  <= 1'b1;
        narrow_data[0] <= '{addr: addr, we: 1'b0, wdata: '0, strb: '0};
        repeat (6) @(posedge clk_i);
        narrow_req[0] <= 1'b0;
      end
      wide_access(addr, 1'b1, wdata64, 8'hFF);
    join
    wide_access(addr, 1'b0, '0, '0);

    test_name = "narrow_arbitration";
    @(posedge clk_i);
    narrow_req     <= 2'b11;
    narrow_data[0] <= '{addr: 32'h0000_0010, we: 1'b0, wdata: '0, strb: '0};
    narrow_data[1] <= '{addr: 32'h0000_0024, we: 1'b0, wdata: '0, strb: '0};
    @(negedge clk_i);
    check_value(64'(2'b11), 64'(narrow_gnt_o));
    // Both ports onto bank 2
    @(posedge clk_i);
    narrow_data[0] <= '{addr: 32'h0000_0048, we: 1'b0, wdata: '0, strb: '0};
    narrow_data[1] <= '{addr: 32'h0000_0088, we: 1'b0, wdata: '0, strb: '0};
    prev_gnt = '0;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_i);
      if (k == 0) begin
        checks++;
        if (!$onehot(narrow_gnt_o)) begin
          errors++;
          $display("Two ports on one bank were not granted one at a time");
        end
      end else begin
        check_value(64'({prev_gnt[0], prev_gnt[1]}), 64'(narrow_gnt_o));
      end
      prev_gnt = narrow_gnt_o;
    end
    @(posedge clk_i);
    narrow_req <= '0;
    repeat (3) @(posedge clk_i);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: wide_splitter.sv
/*
  Wide port splitter onto the two sub-banks of one wide bank.
  All-or-nothing grant and read data join one cycle later.
*/
`timescale 1ns/1ps

module wide_splitter
  import mem_island_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  wide_req_t                                 data_i,
  output logic      [NumBanks-1:0]                  bank_valid_o,
  output bank_req_t [NumBanks-1:0]                  bank_req_o,
  input  logic      [NumBanks-1:0]                  bank_accept_i,
  output logic                                      gnt_o,
  input  logic      [NumBanks-1:0][NarrowDataWidth-1:0] rdata_i,
  output logic                                      rvalid_o,
  output logic      [WideDataWidth-1:0]             rdata_o
);

  localparam int unsigned WselWidth = $clog2(NumWideBanks);
  localparam int unsigned WselLsb   = ByteOffWidth + $clog2(NumSubBanks);

  logic [WselWidth-1:0] wsel;
  logic [WselWidth-1:0] wsel_q;
  logic                 rvalid_q;

  assign wsel = data_i.addr[WselLsb +: WselWidth];

  // Both halves must be free of narrow traffic
  assign gnt_o = req_i & (&bank_accept_i[wsel * NumSubBanks +: NumSubBanks]);

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    localparam int unsigned W = b / NumSubBanks;
    localparam int unsigned S = b % NumSubBanks;

    assign bank_valid_o[b]     = gnt_o && (wsel == WselWidth'(W));
    assign bank_req_o[b].addr  = data_i.addr[BankAddrLsb +: BankAddrWidth];
    assign bank_req_o[b].we    = data_i.we;
    assign bank_req_o[b].wdata = data_i.wdata[S * NarrowDataWidth +: NarrowDataWidth];
    assign bank_req_o[b].strb  = data_i.strb[S * NarrowStrbWidth +: NarrowStrbWidth];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      wsel_q   <= '0;
    end else begin
      rvalid_q <= gnt_o;
      wsel_q   <= wsel;
    end
  end

  assign rvalid_o = rvalid_q;
  // Sub-bank 1 forms the upper half
  assign rdata_o  = rdata_i[wsel_q * NumSubBanks +: NumSubBanks];

endmodule
